/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_zet_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb.f */
+incdir+.
zet_pkg.sv
zet_uop_if.sv
zet_fetch.sv
zet_decode.sv
zet_micro_data.sv
zet_exec.sv
zet_core.sv
zet_core_props.sv
tb_zet_core.sv

/* tb_zet_core.sv */
`include "zet_defines.svh"

module tb_zet_core;
  timeunit 1ns;
  timeprecision 1ps;

  import zet_pkg::*;

  logic        clk = 1'b0;
  logic        rst_n_i = 1'b0;
  logic        intr_i = 1'b0;
  logic        inta_o;
  addr_t       cpu_adr_o;
  word_t       cpu_dat_i = '0;
  word_t       cpu_dat_o;
  logic        cpu_byte_o;
  logic        cpu_block_i = 1'b1;
  logic        cpu_mem_op_o;
  logic        cpu_m_io_o;
  logic        cpu_we_o;
  addr_t       pc_o;

  // program image, copied into the memory model while reset is held
  logic [7:0]  image [65536];
  logic [7:0]  mem [65536];
  logic [15:0] load_ptr = 16'h0000;

  // write logs, cleared by reset
  word_t       io_port_q [$];
  word_t       io_data_q [$];
  word_t       st_addr_q [$];
  word_t       st_data_q [$];
  logic        st_byte_q [$];
  int          inta_cnt = 0;

  logic        stall_en = 1'b0;
  logic [31:0] stall_lfsr = 32'h9b55;
  logic [31:0] data_lfsr = 32'h9b55;

  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;

  zet_core i_zet_core (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .intr_i       (intr_i),
    .inta_o       (inta_o),
    .cpu_adr_o    (cpu_adr_o),
    .cpu_dat_i    (cpu_dat_i),
    .cpu_dat_o    (cpu_dat_o),
    .cpu_byte_o   (cpu_byte_o),
    .cpu_block_i  (cpu_block_i),
    .cpu_mem_op_o (cpu_mem_op_o),
    .cpu_m_io_o   (cpu_m_io_o),
    .cpu_we_o     (cpu_we_o),
    .pc_o         (pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // memory and io model
  // block high by default, one free cycle per access after the address settles
  always @(posedge clk) begin : mem_model
    logic [15:0] a;
    logic [15:0] a_nx;
    logic        hold;
    int          i;
    a    = cpu_adr_o[15:0];
    a_nx = a + 16'd1;
    hold = 1'b0;
    if (!rst_n_i) begin
      for (i = 0; i < 65536; i++) begin
        mem[i] = image[i];
      end
      io_port_q.delete();
      io_data_q.delete();
      st_addr_q.delete();
      st_data_q.delete();
      st_byte_q.delete();
      inta_cnt    <= 0;
      cpu_block_i <= 1'b1;
    end else begin
      if (inta_o) begin
        inta_cnt <= inta_cnt + 1;
      end
      if (cpu_block_i) begin
        // extra stall when two lfsr bits are both set
        if (stall_en) begin
          stall_lfsr = lfsr_next(stall_lfsr);
          hold       = stall_lfsr[0];
          stall_lfsr = lfsr_next(stall_lfsr);
          hold       = hold & stall_lfsr[0];
        end
        // address moves after the acknowledge cycle, so wait one more
        if (!inta_o && !hold) begin
          cpu_block_i <= 1'b0;
          // data only for a requested access
          if (!cpu_mem_op_o) begin
            cpu_dat_i <= 16'h0000;
          end else if (cpu_byte_o) begin
            cpu_dat_i <= {8'h00, mem[a]};
          end else begin
            cpu_dat_i <= {mem[a_nx], mem[a]};
          end
        end
      end else begin
        cpu_block_i <= 1'b1;
        // write completes in this free cycle
        if (cpu_mem_op_o && cpu_we_o) begin
          if (cpu_m_io_o) begin
            io_port_q.push_back(a);
            io_data_q.push_back(cpu_dat_o);
          end else begin
            mem[a]    = cpu_dat_o[7:0];
            mem[a_nx] = cpu_dat_o[15:8];
            st_addr_q.push_back(a);
            st_data_q.push_back(cpu_dat_o);
            st_byte_q.push_back(cpu_byte_o);
          end
        end
      end
    end
  end

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    assert (got == exp) else begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_io(input int idx, input word_t port, input word_t value);
    checks++;
    assert (idx < io_data_q.size()) else begin
      $display("IO write number %0d never happened (time %0t)", idx, $time);
      errors++;
    end
    if (idx < io_data_q.size()) begin
      check_word(io_port_q[idx], port, "io port");
      check_word(io_data_q[idx], value, "io value");
    end
  endtask

  task automatic wait_io(input int n, input int limit);
    int cyc;
    cyc = 0;
    while (io_data_q.size() < n && cyc < limit) begin
      @(negedge clk);
      cyc++;
    end
    if (io_data_q.size() < n) begin
      $display("timed out waiting for %0d IO writes at %0t", n, $time);
      timeouts++;
    end
  endtask

  task automatic wait_pc(input addr_t target, input int limit);
    int cyc;
    cyc = 0;
    while (pc_o !== target && cyc < limit) begin
      @(negedge clk);
      cyc++;
    end
    if (pc_o !== target) begin
      $display("timed out waiting for the core to reach %h at %0t", target, $time);
      timeouts++;
    end
  endtask

  task automatic wait_inta(input int limit);
    int cyc;
    cyc = 0;
    while (inta_cnt == 0 && cyc < limit) begin
      @(negedge clk);
      cyc++;
    end
    if (inta_cnt == 0) begin
      $display("timed out waiting for an interrupt acknowledge at %0t", $time);
      timeouts++;
    end
  endtask

  // code given msb first, n bytes
  task automatic emit(input logic [63:0] code, input int n);
    int k;
    for (k = 0; k < n; k++) begin
      image[load_ptr] = code[8*(n-1-k) +: 8];
      load_ptr        = load_ptr + 16'd1;
    end
  endtask

  task automatic start_case(input logic stall);
    int i;
    @(posedge clk);
    stall_en <= stall;
    intr_i   <= 1'b0;
    // fill depends on both address bytes
    for (i = 0; i < 65536; i++) begin
      image[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h3C;
    end
    load_ptr = 16'h0000;
  endtask

  task automatic reset_core();
    @(posedge clk);
    rst_n_i <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n_i <= 1'b1;
  endtask

  task automatic mov_out_case();
    start_case(1'b0);
    emit(64'hBA3412, 3);   // mov dx,1234h
    emit(64'hB8CDAB, 3);   // mov ax,abcdh
    emit(64'hEF, 1);       // out dx,ax
    emit(64'hF4, 1);
    reset_core();
    wait_io(1, 2000);
    wait_pc(20'h00008, 2000);
    check_count(io_data_q.size(), 1, "io writes in mov/out");
    check_io(0, 16'h1234, 16'hABCD);
  endtask

  task automatic count_loop();
    word_t sum;
    int    cx;
    start_case(1'b0);
    emit(64'hBA2000, 3);   // mov dx,20h
    emit(64'hB80000, 3);   // mov ax,0
    emit(64'hB90500, 3);   // mov cx,5
    emit(64'hBB0300, 3);   // mov bx,3
    emit(64'hBE0100, 3);   // mov si,1
    emit(64'h01D8, 2);     // 0fh: add ax,bx
    emit(64'h29F1, 2);     // sub cx,si
    emit(64'h75FA, 2);     // jnz 0fh
    emit(64'hEF, 1);
    emit(64'hF4, 1);
    // ax gains 3 for every pass until cx hits zero
    sum = 16'h0000;
    for (cx = 5; cx > 0; cx--) begin
      sum = sum + 16'd3;
    end
    reset_core();
    wait_io(1, 4000);
    wait_pc(20'h00017, 4000);
    check_count(io_data_q.size(), 1, "io writes in loop");
    check_io(0, 16'h0020, sum);
  endtask

  task automatic store_load();
    word_t v;
    int    k;
    for (k = 0; k < 16; k++) begin
      data_lfsr = lfsr_next(data_lfsr);
      v[k]      = data_lfsr[0];
    end
    start_case(1'b1);
    emit(64'hBA3000, 3);   // mov dx,30h
    emit(64'hBB0004, 3);   // mov bx,0400h
    emit({40'h0, 8'hB8, v[7:0], v[15:8]}, 3);
    emit(64'h8907, 2);     // mov [bx],ax
    emit(64'h29C0, 2);     // sub ax,ax
    emit(64'h8B0F, 2);     // mov cx,[bx]
    emit(64'h89C8, 2);     // mov ax,cx
    emit(64'hEF, 1);
    emit(64'hF4, 1);
    reset_core();
    wait_io(1, 8000);
    wait_pc(20'h00013, 8000);
    check_count(st_data_q.size(), 1, "memory writes");
    if (st_data_q.size() > 0) begin
      check_word(st_addr_q[0], 16'h0400, "store address");
      check_word(st_data_q[0], v, "store data");
      // stores are word accesses
      check_count(st_byte_q[0], 0, "store byte flag");
    end
    check_word({mem[16'h0401], mem[16'h0400]}, v, "memory word at bx");
    check_count(io_data_q.size(), 1, "io writes in store/load");
    check_io(0, 16'h0030, v);
  endtask

  task automatic halt_interrupt();
    start_case(1'b0);
    emit(64'hBA1000, 3);   // mov dx,10h
    emit(64'hB81100, 3);   // mov ax,11h
    emit(64'hEF, 1);
    emit(64'hFB, 1);       // sti
    emit(64'hF4, 1);       // 08h: hlt
    emit(64'hB85500, 3);   // mov ax,55h
    emit(64'hEF, 1);
    emit(64'hF4, 1);
    // handler at the interrupt vector
    load_ptr = `ZET_INT_VECTOR;
    emit(64'hB8AA00, 3);   // mov ax,0aah
    emit(64'hEF, 1);
    emit(64'hCF, 1);       // iret
    reset_core();
    wait_io(1, 2000);
    wait_pc(20'h00009, 2000);
    check_count(inta_cnt, 0, "acknowledges before intr");
    @(posedge clk);
    intr_i <= 1'b1;
    wait_inta(200);
    @(posedge clk);
    intr_i <= 1'b0;
    wait_io(3, 2000);
    wait_pc(20'h0000E, 2000);
    check_count(inta_cnt, 1, "acknowledge pulses");
    check_count(io_data_q.size(), 3, "io writes around the interrupt");
    check_io(0, 16'h0010, 16'h0011);
    check_io(1, 16'h0010, 16'h00AA);
    check_io(2, 16'h0010, 16'h0055);
  endtask

  task automatic cli_mask();
    start_case(1'b0);
    emit(64'hFB, 1);       // sti
    emit(64'hFA, 1);       // cli
    emit(64'hBA5000, 3);   // mov dx,50h
    emit(64'hB80100, 3);
    emit(64'hEF, 1);
    emit(64'hB80200, 3);
    emit(64'hEF, 1);
    emit(64'hF4, 1);
    reset_core();
    wait_io(1, 2000);
    // IF has been set and cleared again, request stays up from here on
    @(posedge clk);
    intr_i <= 1'b1;
    wait_io(2, 2000);
    wait_pc(20'h0000E, 2000);
    // halted with IF clear, give the request time to leak through
    repeat (20) @(negedge clk);
    check_count(inta_cnt, 0, "acknowledges with IF clear");
    check_count(io_data_q.size(), 2, "io writes with IF clear");
    check_io(0, 16'h0050, 16'h0001);
    check_io(1, 16'h0050, 16'h0002);
    @(posedge clk);
    intr_i <= 1'b0;
  endtask

  task automatic jump_skip();
    start_case(1'b0);
    emit(64'hBA6000, 3);   // mov dx,60h
    emit(64'hB87700, 3);   // mov ax,77h
    emit(64'hEB04, 2);     // jmp 0ch
    emit(64'hB89900, 3);   // skipped
    emit(64'hEF, 1);       // skipped
    emit(64'h27, 1);       // 0ch: not in the subset
    emit(64'h89C1, 2);     // mov cx,ax
    emit(64'hB80000, 3);
    emit(64'h89C8, 2);     // mov ax,cx
    emit(64'hEF, 1);
    emit(64'hF4, 1);
    reset_core();
    wait_io(1, 2000);
    wait_pc(20'h00016, 2000);
    check_count(io_data_q.size(), 1, "io writes after jmp");
    check_io(0, 16'h0060, 16'h0077);
  endtask

  initial begin
    mov_out_case();
    count_loop();
    store_load();
    halt_interrupt();
    cli_mask();
    jump_skip();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* zet_core.sv */
module zet_core (
  input  logic           clk,
  input  logic           rst_n_i,
  input  logic           intr_i,
  output logic           inta_o,
  output zet_pkg::addr_t cpu_adr_o,
  input  zet_pkg::word_t cpu_dat_i,
  output zet_pkg::word_t cpu_dat_o,
  output logic           cpu_byte_o,
  input  logic           cpu_block_i,
  output logic           cpu_mem_op_o,
  output logic           cpu_m_io_o,
  output logic           cpu_we_o,
  output zet_pkg::addr_t pc_o
);
  import zet_pkg::*;

  zet_uop_if uop ();

  // fetch and decode
  logic [7:0] opcode;
  logic [7:0] modrm;
  logic       ld_base;
  logic       need_modrm;
  logic       need_imm;
  logic       imm_size;
  word_t      imm_l;

  // fetch and exec
  logic [1:0] ins_len;
  logic       exec_st;
  logic       int_take;
  logic       fetch_req;
  word_t      ip;
  word_t      fetch_off;
  logic       ifl;
  logic       done;

  // exec bus side
  addr_t      addr_exec;
  logic       mem_rd;
  logic       byte_exec;

  zet_fetch i_fetch (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .cpu_dat_i    (cpu_dat_i),
    .cpu_block_i  (cpu_block_i),
    .intr_i       (intr_i),
    .need_modrm_i (need_modrm),
    .need_imm_i   (need_imm),
    .imm_size_i   (imm_size),
    .ip_i         (ip),
    .ifl_i        (ifl),
    .done_i       (done),
    .opcode_o     (opcode),
    .modrm_o      (modrm),
    .ld_base_o    (ld_base),
    .imm_l_o      (imm_l),
    .ins_len_o    (ins_len),
    .exec_st_o    (exec_st),
    .int_take_o   (int_take),
    .inta_o       (inta_o),
    .fetch_req_o  (fetch_req)
  );

  zet_decode i_decode (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .opcode_i     (opcode),
    .modrm_i      (modrm),
    .ld_base_i    (ld_base),
    .uop          (uop),
    .need_modrm_o (need_modrm),
    .need_imm_o   (need_imm),
    .imm_size_o   (imm_size)
  );

  zet_micro_data i_micro_data (
    .uop   (uop),
    .imm_i (imm_l)
  );

  zet_exec i_exec (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .uop         (uop),
    .exec_st_i   (exec_st),
    .int_take_i  (int_take),
    .ins_len_i   (ins_len),
    .cpu_dat_i   (cpu_dat_i),
    .cpu_block_i (cpu_block_i),
    .wr_data_o   (cpu_dat_o),
    .addr_o      (addr_exec),
    .we_o        (cpu_we_o),
    .m_io_o      (cpu_m_io_o),
    .mem_rd_o    (mem_rd),
    .byte_o      (byte_exec),
    .ip_o        (ip),
    .zf_o        (),
    .ifl_o       (ifl),
    .done_o      (done)
  );

  // next instruction byte sits at ip plus bytes taken
  assign fetch_off    = ip + word_t'(ins_len);
  assign cpu_adr_o    = exec_st ? addr_exec : addr_t'(fetch_off);
  // fetches are byte reads
  assign cpu_byte_o   = exec_st ? byte_exec : 1'b1;
  assign cpu_mem_op_o = fetch_req | mem_rd | cpu_we_o;
  assign pc_o         = addr_t'(ip);

endmodule

/* zet_core_props.sv */
module zet_core_props (
  input logic           clk,
  input logic           rst_n_i,
  input logic           inta_o,
  input logic           cpu_block_i,
  input logic           cpu_mem_op_o,
  input logic           cpu_we_o,
  input zet_pkg::addr_t cpu_adr_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // acknowledge is a one-cycle pulse
  inta_pulse_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    inta_o |=> !inta_o)
    else $error("inta_o high for two cycles in a row");

  // blocked write stays a write request
  we_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    cpu_we_o && cpu_block_i |=> cpu_we_o && cpu_mem_op_o)
    else $error("write request dropped while the access was blocked");

  // stalled request keeps its address
  adr_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    cpu_block_i && cpu_mem_op_o |=> $stable(cpu_adr_o))
    else $error("cpu_adr_o moved while the access was blocked");

endmodule

bind zet_core zet_core_props i_core_props (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .inta_o       (inta_o),
  .cpu_block_i  (cpu_block_i),
  .cpu_mem_op_o (cpu_mem_op_o),
  .cpu_we_o     (cpu_we_o),
  .cpu_adr_o    (cpu_adr_o)
);

/* zet_decode.sv */
`include "zet_defines.svh"

module zet_decode (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic [7:0] opcode_i,
  input  logic [7:0] modrm_i,
  input  logic       ld_base_i,
  zet_uop_if.decoder uop,
  output logic       need_modrm_o,
  output logic       need_imm_o,
  output logic       imm_size_o
);
  import zet_pkg::*;

  localparam reg_idx_t REG_AX = 3'd0;
  localparam reg_idx_t REG_DX = 3'd2;
  localparam reg_idx_t REG_BX = 3'd3;

  logic [7:0] op_q;
  logic [7:0] opc;
  logic       mod_reg;
  logic       mod_bx;
  reg_idx_t   rm;
  reg_idx_t   rg;

  // opcode held for the rest of the instruction
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      op_q <= 8'h90;
    end else if (ld_base_i) begin
      op_q <= opcode_i;
    end
  end

  // live byte in the opcode cycle, so byte needs are known at once
  assign opc     = ld_base_i ? opcode_i : op_q;
  assign mod_reg = modrm_i[7:6] == 2'b11;
  // only [bx] addressing is kept
  assign mod_bx  = (modrm_i[7:6] == 2'b00) && (modrm_i[2:0] == 3'b111);
  assign rm      = modrm_i[2:0];
  assign rg      = modrm_i[5:3];

  always_comb begin
    uop.seq_addr = `ZET_UOP_NOP;
    uop.src      = rg;
    uop.dst      = rm;
    need_modrm_o = 1'b0;
    need_imm_o   = 1'b0;
    imm_size_o   = 1'b0;
    casez (opc)
      // mov reg,imm16, register in the opcode
      8'b1011_1???: begin
        uop.seq_addr = `ZET_UOP_MOV_RI;
        uop.dst      = opc[2:0];
        need_imm_o   = 1'b1;
        imm_size_o   = 1'b1;
      end
      8'h89: begin
        need_modrm_o = 1'b1;
        if (mod_reg) begin
          uop.seq_addr = `ZET_UOP_MOV_RR;
        end else if (mod_bx) begin
          // store, bx as base
          uop.seq_addr = `ZET_UOP_STORE;
          uop.dst      = REG_BX;
        end
      end
      8'h01, 8'h29: begin
        need_modrm_o = 1'b1;
        if (mod_reg) begin
          uop.seq_addr = opc[5] ? `ZET_UOP_SUB_RR : `ZET_UOP_ADD_RR;
        end
      end
      8'h8B: begin
        need_modrm_o = 1'b1;
        if (mod_bx) begin
          uop.seq_addr = `ZET_UOP_LOAD;
          uop.dst      = rg;
          uop.src      = REG_BX;
        end
      end
      // out dx,ax
      8'hEF: begin
        uop.seq_addr = `ZET_UOP_OUT;
        uop.src      = REG_AX;
        uop.dst      = REG_DX;
      end
      8'hEB, 8'h75: begin
        uop.seq_addr = opc[7] ? `ZET_UOP_JMP : `ZET_UOP_JNZ;
        need_imm_o   = 1'b1;
      end
      8'hFA: uop.seq_addr = `ZET_UOP_CLI;
      8'hFB: uop.seq_addr = `ZET_UOP_STI;
      8'hF4: uop.seq_addr = `ZET_UOP_HLT;
      8'hCF: uop.seq_addr = `ZET_UOP_IRET;
      default: ;
    endcase
  end

endmodule

/* zet_defines.svh */
`ifndef ZET_DEFINES_SVH
`define ZET_DEFINES_SVH

// bus and rom widths
`define ZET_ADDR_W       20
`define ZET_MICRO_ADDR_W 4
`define ZET_IR_W         20

// ip after reset, ip on interrupt entry
`define ZET_RESET_IP     16'h0000
`define ZET_INT_VECTOR   16'h0080

// control word bit positions
`define ZET_IR_ALU_L     0
`define ZET_IR_DST_L     2
`define ZET_IR_SRC_L     5
`define ZET_IR_IMM       8
`define ZET_IR_REG_WE    9
`define ZET_IR_FLAG_WE   10
`define ZET_IR_MEM_RD    11
`define ZET_IR_MEM_WR    12
`define ZET_IR_IO_WR     13
`define ZET_IR_JMP       14
`define ZET_IR_COND      15
`define ZET_IR_IF_SET    16
`define ZET_IR_IF_CLR    17
`define ZET_IR_HALT      18
`define ZET_IR_IRET      19

// alu op field
`define ZET_ALU_MOV      2'd0
`define ZET_ALU_ADD      2'd1
`define ZET_ALU_SUB      2'd2

// micro rom entries, one per instruction
`define ZET_UOP_NOP      4'd0
`define ZET_UOP_MOV_RI   4'd1
`define ZET_UOP_MOV_RR   4'd2
`define ZET_UOP_ADD_RR   4'd3
`define ZET_UOP_SUB_RR   4'd4
`define ZET_UOP_STORE    4'd5
`define ZET_UOP_LOAD     4'd6
`define ZET_UOP_OUT      4'd7
`define ZET_UOP_JMP      4'd8
`define ZET_UOP_JNZ      4'd9
`define ZET_UOP_CLI      4'd10
`define ZET_UOP_STI      4'd11
`define ZET_UOP_HLT      4'd12
`define ZET_UOP_IRET     4'd13

`endif

/* zet_exec.sv */
`include "zet_defines.svh"

module zet_exec (
  input  logic           clk,
  input  logic           rst_n_i,
  zet_uop_if.exec        uop,
  input  logic           exec_st_i,
  input  logic           int_take_i,
  input  logic [1:0]     ins_len_i,
  input  zet_pkg::word_t cpu_dat_i,
  input  logic           cpu_block_i,
  output zet_pkg::word_t wr_data_o,
  output zet_pkg::addr_t addr_o,
  output logic           we_o,
  output logic           m_io_o,
  output logic           mem_rd_o,
  output logic           byte_o,
  output zet_pkg::word_t ip_o,
  output logic           zf_o,
  output logic           ifl_o,
  output logic           done_o
);
  import zet_pkg::*;

  word_t      regs [8];
  word_t      ip_q;
  word_t      saved_ip_q;
  word_t      op_a;
  word_t      op_b;
  word_t      alu_y;
  word_t      ip_seq;
  reg_idx_t   dst;
  reg_idx_t   src;
  logic [1:0] alu_op;
  logic       take_jmp;

  // control word fields
  assign dst    = uop.ir[`ZET_IR_DST_L +: 3];
  assign src    = uop.ir[`ZET_IR_SRC_L +: 3];
  assign alu_op = uop.ir[`ZET_IR_ALU_L +: 2];

  // alu, dst op src or dst op imm
  assign op_a = regs[dst];
  assign op_b = uop.ir[`ZET_IR_IMM] ? uop.imm : regs[src];

  always_comb begin
    case (alu_op)
      `ZET_ALU_ADD: alu_y = op_a + op_b;
      `ZET_ALU_SUB: alu_y = op_a - op_b;
      default:      alu_y = op_b;
    endcase
  end

  // data side of the bus, only while in exec
  assign mem_rd_o  = exec_st_i & uop.ir[`ZET_IR_MEM_RD];
  assign we_o      = exec_st_i & (uop.ir[`ZET_IR_MEM_WR] | uop.ir[`ZET_IR_IO_WR]);
  assign m_io_o    = exec_st_i & uop.ir[`ZET_IR_IO_WR];
  // word accesses only
  assign byte_o    = 1'b0;
  // load address in src, store address and port in dst
  assign addr_o    = addr_t'(uop.ir[`ZET_IR_MEM_RD] ? regs[src] : regs[dst]);
  assign wr_data_o = regs[src];

  // a stall holds the step, access or not
  assign done_o   = exec_st_i & ~cpu_block_i;
  assign ip_seq   = ip_q + word_t'(ins_len_i);
  // jnz falls through on zero
  assign take_jmp = uop.ir[`ZET_IR_JMP] & ~(uop.ir[`ZET_IR_COND] & zf_o);
  assign ip_o     = ip_q;

  // register file
  always_ff @(posedge clk) begin
    if (done_o && uop.ir[`ZET_IR_REG_WE]) begin
      regs[dst] <= uop.ir[`ZET_IR_MEM_RD] ? cpu_dat_i : alu_y;
    end
  end

  // return address, single level
  always_ff @(posedge clk) begin
    if (int_take_i) begin
      saved_ip_q <= ip_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ip_q  <= `ZET_RESET_IP;
      zf_o  <= 1'b0;
      ifl_o <= 1'b0;
    end else if (int_take_i) begin
      // ip already points past the interrupted instruction
      ip_q  <= `ZET_INT_VECTOR;
      ifl_o <= 1'b0;
    end else if (done_o) begin
      if (uop.ir[`ZET_IR_IRET]) begin
        ip_q <= saved_ip_q;
      end else if (take_jmp) begin
        ip_q <= ip_seq + uop.off;
      end else begin
        ip_q <= ip_seq;
      end
      if (uop.ir[`ZET_IR_FLAG_WE]) begin
        zf_o <= alu_y == 16'h0000;
      end
      if (uop.ir[`ZET_IR_IF_SET]) begin
        ifl_o <= 1'b1;
      end else if (uop.ir[`ZET_IR_IF_CLR]) begin
        ifl_o <= 1'b0;
      end
    end
  end

endmodule

/* zet_fetch.sv */
module zet_fetch (
  input  logic           clk,
  input  logic           rst_n_i,
  input  zet_pkg::word_t cpu_dat_i,
  input  logic           cpu_block_i,
  input  logic           intr_i,
  input  logic           need_modrm_i,
  input  logic           need_imm_i,
  input  logic           imm_size_i,
  input  zet_pkg::word_t ip_i,
  input  logic           ifl_i,
  input  logic           done_i,
  output logic [7:0]     opcode_o,
  output logic [7:0]     modrm_o,
  output logic           ld_base_o,
  output zet_pkg::word_t imm_l_o,
  output logic [1:0]     ins_len_o,
  output logic           exec_st_o,
  output logic           int_take_o,
  output logic           inta_o,
  output logic           fetch_req_o
);
  import zet_pkg::*;

  fetch_state_t state_q;
  fetch_state_t state_d;
  logic [1:0]   len_q;
  logic [7:0]   imm_lo_q;
  logic [7:0]   imm_hi_q;
  logic         halt_q;
  logic         boot_q;
  logic         byte_ok;
  logic         int_req;

  assign fetch_req_o = (state_q == OPCODE) || (state_q == MODRM) ||
                       (state_q == IMM_LO) || (state_q == IMM_HI);
  // one instruction byte per unstalled access
  assign byte_ok     = fetch_req_o & ~cpu_block_i;
  assign int_req     = intr_i & ifl_i;

  assign exec_st_o  = state_q == EXEC;
  assign int_take_o = state_q == INT_ACK;
  assign inta_o     = int_take_o;
  // decode latches the live byte on this pulse
  assign ld_base_o  = (state_q == OPCODE) & ~cpu_block_i;
  assign opcode_o   = cpu_dat_i[7:0];
  assign imm_l_o    = {imm_hi_q, imm_lo_q};
  // bytes taken so far, also the fetch offset from ip
  assign ins_len_o  = len_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      OPCODE:  state_d = need_modrm_i ? MODRM : (need_imm_i ? IMM_LO : EXEC);
      MODRM:   state_d = need_imm_i ? IMM_LO : EXEC;
      IMM_LO:  state_d = imm_size_i ? IMM_HI : EXEC;
      IMM_HI:  state_d = EXEC;
      EXEC: begin
        // instruction boundary
        if (done_i) begin
          if (int_req) begin
            state_d = INT_ACK;
          end else if (halt_q) begin
            state_d = HALT;
          end else begin
            state_d = OPCODE;
          end
        end
      end
      INT_ACK: state_d = OPCODE;
      HALT: begin
        if (boot_q) begin
          state_d = OPCODE;
        end else if (int_req) begin
          state_d = INT_ACK;
        end
      end
      default: state_d = OPCODE;
    endcase
    // stall freezes everything but the one-cycle acknowledge
    if (cpu_block_i && state_q != INT_ACK) begin
      state_d = state_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      // park in halt, leave on the first free cycle
      state_q <= HALT;
      boot_q  <= 1'b1;
      len_q   <= 2'd0;
      halt_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_d == OPCODE) begin
        boot_q <= 1'b0;
      end
      if (byte_ok) begin
        len_q <= len_q + 2'd1;
      end else if (exec_st_o && done_i) begin
        len_q <= 2'd0;
      end
      // hlt is the one opcode fetch itself must see
      if (ld_base_o) begin
        halt_q <= cpu_dat_i[7:0] == 8'hF4;
      end
    end
  end

  // instruction bytes
  always_ff @(posedge clk) begin
    if (byte_ok) begin
      case (state_q)
        MODRM:  modrm_o <= cpu_dat_i[7:0];
        IMM_LO: begin
          imm_lo_q <= cpu_dat_i[7:0];
          imm_hi_q <= 8'h00;
        end
        IMM_HI: imm_hi_q <= cpu_dat_i[7:0];
        default: ;
      endcase
    end
  end

endmodule

/* zet_micro_data.sv */
`include "zet_defines.svh"

module zet_micro_data (
  zet_uop_if.rom        uop,
  input zet_pkg::word_t imm_i
);
  import zet_pkg::*;

  ir_t rom_w;

  // one control word per instruction, register fields left zero
  always_comb begin
    rom_w = '0;
    case (uop.seq_addr)
      `ZET_UOP_MOV_RI: begin
        rom_w[`ZET_IR_IMM]    = 1'b1;
        rom_w[`ZET_IR_REG_WE] = 1'b1;
      end
      `ZET_UOP_MOV_RR: rom_w[`ZET_IR_REG_WE] = 1'b1;
      `ZET_UOP_ADD_RR, `ZET_UOP_SUB_RR: begin
        rom_w[`ZET_IR_ALU_L +: 2] = (uop.seq_addr == `ZET_UOP_ADD_RR) ?
                                    `ZET_ALU_ADD : `ZET_ALU_SUB;
        rom_w[`ZET_IR_REG_WE]     = 1'b1;
        rom_w[`ZET_IR_FLAG_WE]    = 1'b1;
      end
      `ZET_UOP_STORE: rom_w[`ZET_IR_MEM_WR] = 1'b1;
      `ZET_UOP_LOAD: begin
        rom_w[`ZET_IR_MEM_RD] = 1'b1;
        rom_w[`ZET_IR_REG_WE] = 1'b1;
      end
      `ZET_UOP_OUT: rom_w[`ZET_IR_IO_WR] = 1'b1;
      `ZET_UOP_JMP: rom_w[`ZET_IR_JMP] = 1'b1;
      `ZET_UOP_JNZ: begin
        rom_w[`ZET_IR_JMP]  = 1'b1;
        rom_w[`ZET_IR_COND] = 1'b1;
      end
      `ZET_UOP_CLI: rom_w[`ZET_IR_IF_CLR] = 1'b1;
      `ZET_UOP_STI: rom_w[`ZET_IR_IF_SET] = 1'b1;
      `ZET_UOP_HLT: rom_w[`ZET_IR_HALT] = 1'b1;
      // entry is only taken with IF set, so iret sets it again
      `ZET_UOP_IRET: begin
        rom_w[`ZET_IR_IRET]   = 1'b1;
        rom_w[`ZET_IR_IF_SET] = 1'b1;
      end
      default: rom_w = '0;
    endcase
  end

  // merge decoder register fields
  always_comb begin
    uop.ir                    = rom_w;
    uop.ir[`ZET_IR_DST_L +: 3] = uop.dst;
    uop.ir[`ZET_IR_SRC_L +: 3] = uop.src;
  end

  assign uop.imm = imm_i;
  // rel8 displacement
  assign uop.off = {{8{imm_i[7]}}, imm_i[7:0]};

endmodule

/* zet_pkg.sv */
`include "zet_defines.svh"

package zet_pkg;

  // data word and physical address
  typedef logic [15:0]                  word_t;
  typedef logic [`ZET_ADDR_W-1:0]       addr_t;

  // register number, 8086 order
  typedef logic [2:0]                   reg_idx_t;

  // micro rom index and control word
  typedef logic [`ZET_MICRO_ADDR_W-1:0] micro_addr_t;
  typedef logic [`ZET_IR_W-1:0]         ir_t;

  typedef enum logic [2:0] {
    OPCODE,
    MODRM,
    IMM_LO,
    IMM_HI,
    EXEC,
    INT_ACK,
    HALT
  } fetch_state_t;

endpackage

/* zet_uop_if.sv */
interface zet_uop_if;
  import zet_pkg::*;

  // request from the decoder
  micro_addr_t seq_addr;
  reg_idx_t    src;
  reg_idx_t    dst;

  // control word and operands out of the rom
  ir_t         ir;
  word_t       imm;
  word_t       off;

  modport decoder (
    output seq_addr, src, dst
  );

  modport rom (
    input  seq_addr, src, dst,
    output ir, imm, off
  );

  modport exec (
    input ir, imm, off
  );

endinterface
